/* Bender.yml */
package:
  name: mmu

sources:
  - verilog/mmuPkg.sv
  - verilog/satpRegs.sv
  - verilog/tlbArray.sv
  - verilog/pageWalker.sv
  - verilog/translateFront.sv
  - verilog/mmuTop.sv
  - target: test
    files:
      - dv/mmuTbMem.sv
      - dv/mmuTb.sv

/* dv/mmuTb.sv */
`timescale 1ns/10ps

module mmuTb;
    import mmuPkg::*;

    localparam int lineWidth = 128;
    localparam int memAddrWidth = 30;
    localparam int tlbEntries = 16;
    localparam int memDepth = 4096;
    localparam int period = 100;
    localparam int resetCycles = 8;
    localparam int plannedRequests = 20;
    // Up to three memory operations of about 6 cycles each, plus response stalls
    localparam int cyclesPerRequest = 80;

    // PTE flag bits
    localparam logic [7:0] flagV = 8'h01;
    localparam logic [7:0] flagR = 8'h02;
    localparam logic [7:0] flagW = 8'h04;
    localparam logic [7:0] flagX = 8'h08;

    logic clk;
    logic rst;
    logic reqValid;
    logic reqReady;
    xlateReqT req;
    logic respValid;
    logic respReady;
    xlateRespT resp;
    logic cfgValid;
    logic cfgReady;
    cfgWriteT cfg;
    logic [memAddrWidth-1:0] memAddr;
    logic memReadEnable;
    logic memWriteEnable;
    logic [lineWidth-1:0] memWriteValue;
    logic memReadDone;
    logic memWriteDone;
    logic [lineWidth-1:0] memReadValue;

    integer seed;
    int respErrors;
    int memErrors;
    int protocolErrors;

    // Reference state
    logic [lineWidth-1:0] refMem [memDepth];
    satpT refSatp;
    logic tlbValid [tlbEntries];
    vpnT tlbTag [tlbEntries];
    logic tlbFault [tlbEntries];
    ppnT tlbPpn [tlbEntries];
    tlbFlagsT tlbFlags [tlbEntries];

    xlateRespT expResp;
    int expReads;
    int expWrites;
    int expLineIdx;

    mmuTop #(
        .lineWidth(lineWidth),
        .memAddrWidth(memAddrWidth),
        .tlbEntries(tlbEntries)
    ) mmuTop_inst (
        .clk(clk),
        .rst(rst),
        .reqValid(reqValid),
        .reqReady(reqReady),
        .req(req),
        .respValid(respValid),
        .respReady(respReady),
        .resp(resp),
        .cfgValid(cfgValid),
        .cfgReady(cfgReady),
        .cfg(cfg),
        .memAddr(memAddr),
        .memReadEnable(memReadEnable),
        .memWriteEnable(memWriteEnable),
        .memWriteValue(memWriteValue),
        .memReadDone(memReadDone),
        .memWriteDone(memWriteDone),
        .memReadValue(memReadValue)
    );

    mmuTbMem #(
        .lineWidth(lineWidth),
        .memAddrWidth(memAddrWidth),
        .depth(memDepth)
    ) tbMem_inst (
        .clk(clk),
        .addr(memAddr),
        .readEnable(memReadEnable),
        .writeEnable(memWriteEnable),
        .writeValue(memWriteValue),
        .readDone(memReadDone),
        .writeDone(memWriteDone),
        .readValue(memReadValue)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

    // ------------------------------
    // Checks

    assert property (@(posedge clk) disable iff (rst)
        respValid && respReady |-> resp == expResp)
    else begin
        respErrors++;
        $display("FAILED at %0t: resp got %h expected %h", $time, $sampled(resp), expResp);
    end

    // Written line, neighbours included, must match the reference table
    assert property (@(posedge clk) disable iff (rst)
        respValid && respReady |-> tbMem_inst.lines[expLineIdx] == refMem[expLineIdx])
    else begin
        memErrors++;
        $display("FAILED at %0t: memory line %0d got %h expected %h", $time, expLineIdx,
                 tbMem_inst.lines[expLineIdx], refMem[expLineIdx]);
    end

    assert property (@(posedge clk) disable iff (rst)
        respValid && respReady |-> tbMem_inst.readCount == expReads)
    else begin
        memErrors++;
        $display("FAILED at %0t: readCount got %0d expected %0d", $time,
                 tbMem_inst.readCount, expReads);
    end

    assert property (@(posedge clk) disable iff (rst)
        respValid && respReady |-> tbMem_inst.writeCount == expWrites)
    else begin
        memErrors++;
        $display("FAILED at %0t: writeCount got %0d expected %0d", $time,
                 tbMem_inst.writeCount, expWrites);
    end

    assert property (@(posedge clk) disable iff (rst)
        respValid && !respReady |=> respValid && resp == $past(resp))
    else begin
        protocolErrors++;
        $display("Response changed or dropped while stalled at %0t", $time);
    end

    assert property (@(posedge clk) disable iff (rst)
        respValid |-> !reqReady)
    else begin
        protocolErrors++;
        $display("Request port ready while a response was pending at %0t", $time);
    end

    // satp writes are always taken
    assert property (@(posedge clk) disable iff (rst)
        cfgValid |-> cfgReady)
    else begin
        protocolErrors++;
        $display("Configuration write refused at %0t", $time);
    end

    assert property (@(posedge clk) disable iff (rst)
        memReadEnable || memWriteEnable |-> memAddr < memDepth)
    else begin
        protocolErrors++;
        $display("Memory access outside the modelled range at %0t", $time);
    end

    // ------------------------------
    // Reference model

    function automatic pageTableEntryT makePte(logic [21:0] ppn, logic [7:0] bits);
        return {ppn, 2'b00, bits};
    endfunction

    function automatic pageTableEntryT getPte(paddrT addr);
        return refMem[addr[15:4]][addr[3:2]*32 +: 32];
    endfunction

    task automatic setPte(input paddrT addr, input pageTableEntryT pte);
        refMem[addr[15:4]][addr[3:2]*32 +: 32] = pte;
    endtask

    task automatic putPte(input logic [21:0] tablePpn, input logic [9:0] index,
                          input pageTableEntryT pte);
        paddrT addr;
        addr = {tablePpn, index, 2'b00};
        setPte(addr, pte);
        tbMem_inst.lines[addr[15:4]][addr[3:2]*32 +: 32] = pte;
    endtask

    function automatic logic badPte(pageTableEntryT pte);
        return !pte.valid || (pte.write && !pte.read);
    endfunction

    task automatic fillRef(input int idx, input vpnT vpn, input logic fault,
                           input ppnT ppn, input pageTableEntryT pte);
        tlbValid[idx] = 1'b1;
        tlbTag[idx] = vpn;
        tlbFault[idx] = fault;
        tlbPpn[idx] = fault ? '0 : ppn;
        tlbFlags[idx] = fault ? '0 : {pte.dirty, pte.user, pte.execute, pte.write, pte.read};
    endtask

    task automatic walkRef(input vpnT vpn, input accessTypeE acc, input int idx);
        paddrT a1;
        paddrT a0;
        pageTableEntryT p1;
        pageTableEntryT p0;
        a1 = {refSatp.ppn, vpn.vpn1, 2'b00};
        p1 = getPte(a1);
        expReads++;
        expLineIdx = a1[15:4];
        if (badPte(p1)) begin
            fillRef(idx, vpn, 1'b1, '0, p1);
        end else if (p1.read || p1.execute) begin
            p1.accessed = 1'b1;
            if (acc == accessStore) begin
                p1.dirty = 1'b1;
            end
            setPte(a1, p1);
            expWrites++;
            fillRef(idx, vpn, 1'b0, {p1.ppn1, vpn.vpn0}, p1);
        end else begin
            a0 = {p1.ppn1, p1.ppn0, vpn.vpn0, 2'b00};
            p0 = getPte(a0);
            expReads++;
            expLineIdx = a0[15:4];
            if (badPte(p0) || !(p0.read || p0.execute)) begin
                fillRef(idx, vpn, 1'b1, '0, p0);
            end else begin
                p0.accessed = 1'b1;
                if (acc == accessStore) begin
                    p0.dirty = 1'b1;
                end
                setPte(a0, p0);
                expWrites++;
                fillRef(idx, vpn, 1'b0, {p0.ppn1, p0.ppn0}, p0);
            end
        end
    endtask

    task automatic predict(input vpnT vpn, input accessTypeE acc);
        int idx;
        logic denied;
        expReads = tbMem_inst.readCount;
        expWrites = tbMem_inst.writeCount;
        if (!refSatp.mode) begin
            expResp.ppn = {2'b00, vpn};
            expResp.fault = 1'b0;
        end else begin
            idx = vpn % tlbEntries;
            if (!tlbValid[idx] || tlbTag[idx] != vpn) begin
                walkRef(vpn, acc, idx);
            end
            case (acc)
                accessInstr: denied = !tlbFlags[idx].execute;
                accessLoad: denied = !tlbFlags[idx].read;
                default: denied = !tlbFlags[idx].write;
            endcase
            expResp.ppn = tlbPpn[idx];
            expResp.fault = tlbFault[idx] || denied;
        end
    endtask

    // ------------------------------
    // Stimulus

    task automatic writeSatp(input logic mode, input logic [21:0] rootPpn);
        cfgValid = 1'b1;
        cfg.satp = '{mode: mode, asid: 9'h0, ppn: rootPpn};
        @(negedge clk);
        cfgValid = 1'b0;
        refSatp = cfg.satp;
        for (int i = 0; i < tlbEntries; i++) begin
            tlbValid[i] = 1'b0;
        end
    endtask

    // Stall cycles hold respReady low while another request waits
    task automatic translate(input logic [9:0] vpn1, input logic [9:0] vpn0,
                             input accessTypeE acc, input int stall);
        vpnT vpn;
        vpn = {vpn1, vpn0};
        predict(vpn, acc);
        reqValid = 1'b1;
        req = '{vpn: vpn, accessType: acc};
        while (!reqReady) begin
            @(negedge clk);
        end
        @(negedge clk);
        reqValid = 1'b0;
        forever begin
            if (stall > 0 && respValid) begin
                respReady = 1'b0;
                reqValid = 1'b1;
                req.vpn = vpn ^ 20'hfffff;
                stall--;
            end else begin
                reqValid = 1'b0;
                respReady = ($random(seed) & 3) != 0;
            end
            if (respValid && respReady) begin
                break;
            end
            @(negedge clk);
        end
        @(negedge clk);
        respReady = 1'b0;
    endtask

    task automatic buildTables();
        // Root A at ppn 1, root B at ppn 2
        putPte(22'd1, 10'd1, makePte(22'd4, flagV));
        putPte(22'd1, 10'd2, makePte({12'h0ab, 10'h0}, flagV | flagR | flagW));
        putPte(22'd1, 10'd3, '0);
        putPte(22'd1, 10'd4, makePte(22'd9, flagV | flagW));
        putPte(22'd1, 10'd5, makePte(22'd6, flagV));
        putPte(22'd4, 10'h10, makePte(22'h12345, flagV | flagR | flagW));
        putPte(22'd4, 10'h11, makePte(22'h22222, flagV | flagR));
        putPte(22'd4, 10'h12, makePte(22'h0a0a0, flagV | flagR | flagW));
        putPte(22'd4, 10'h13, makePte(22'h00777, flagV | flagR | flagW | flagX));
        putPte(22'd6, 10'h07, makePte(22'd7, flagV));
        putPte(22'd2, 10'd1, makePte(22'd5, flagV));
        putPte(22'd5, 10'h10, makePte(22'h0beef, flagV | flagR | flagW));
    endtask

    initial begin
        #((resetCycles + plannedRequests * cyclesPerRequest) * period);
        $display("Timeout: the test sequence did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        seed = 32'h0534_ee97;
        respErrors = 0;
        memErrors = 0;
        protocolErrors = 0;
        rst = 1'b1;
        reqValid = 1'b0;
        req = '0;
        respReady = 1'b0;
        cfgValid = 1'b0;
        cfg = '0;
        refSatp = '0;
        expResp = '0;
        expReads = 0;
        expWrites = 0;
        expLineIdx = 0;
        for (int i = 0; i < memDepth; i++) begin
            refMem[i] = '0;
        end
        for (int i = 0; i < tlbEntries; i++) begin
            tlbValid[i] = 1'b0;
        end
        repeat (resetCycles) @(negedge clk);
        rst = 1'b0;
        buildTables();

        // Bare mode
        for (int i = 0; i < 4; i++) begin
            translate($random(seed), $random(seed), accessLoad, 0);
        end

        writeSatp(1'b1, 22'd1);
        translate(10'd1, 10'h10, accessLoad, 0);
        translate(10'd1, 10'h13, accessStore, 0);
        translate(10'd1, 10'h11, accessLoad, 0);
        translate(10'd1, 10'h11, accessStore, 0);
        translate(10'd1, 10'h12, accessInstr, 0);
        translate(10'd2, 10'h05, accessLoad, 0);
        translate(10'd3, 10'h00, accessLoad, 0);
        translate(10'd3, 10'h00, accessLoad, 0);
        translate(10'd4, 10'h01, accessLoad, 0);
        translate(10'd5, 10'h07, accessLoad, 0);
        translate(10'd5, 10'h07, accessStore, 0);
        translate(10'd1, 10'h10, accessLoad, 0);

        // Same root again still flushes
        writeSatp(1'b1, 22'd1);
        translate(10'd1, 10'h10, accessLoad, 0);
        writeSatp(1'b1, 22'd2);
        translate(10'd1, 10'h10, accessLoad, 0);

        translate(10'd1, 10'h10, accessLoad, 6);
        translate(10'd1, 10'h10, accessStore, 3);

        repeat (4) @(negedge clk);
        $display("Errors: response %0d, memory %0d, protocol %0d",
                 respErrors, memErrors, protocolErrors);
        if (respErrors + memErrors + protocolErrors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* dv/mmuTbMem.sv */
`timescale 1ns/10ps

module mmuTbMem #(
    parameter int lineWidth = 128,
    parameter int memAddrWidth = 30,
    parameter int depth = 4096
) (
    input  logic clk,
    input  logic [memAddrWidth-1:0] addr,
    input  logic readEnable,
    input  logic writeEnable,
    input  logic [lineWidth-1:0] writeValue,
    output logic readDone,
    output logic writeDone,
    output logic [lineWidth-1:0] readValue
);

    logic [lineWidth-1:0] lines [depth];
    int readCount;
    int writeCount;
    int waitLeft;
    integer seed;

    initial begin
        seed = 32'h0534_ee97;
        readCount = 0;
        writeCount = 0;
        waitLeft = 0;
        readDone = 1'b0;
        writeDone = 1'b0;
        readValue = '0;
        for (int i = 0; i < depth; i++) begin
            lines[i] = '0;
        end
    end

    // Done pulses for one cycle, 1 to 4 cycles after the enable is seen
    always @(negedge clk) begin
        if (readDone || writeDone) begin
            readDone = 1'b0;
            writeDone = 1'b0;
        end else if (readEnable || writeEnable) begin
            if (waitLeft == 0) begin
                waitLeft = 1 + ($unsigned($random(seed)) % 4);
            end
            waitLeft = waitLeft - 1;
            if (waitLeft == 0) begin
                if (readEnable) begin
                    readValue = lines[addr % depth];
                    readCount = readCount + 1;
                    readDone = 1'b1;
                end else begin
                    lines[addr % depth] = writeValue;
                    writeCount = writeCount + 1;
                    writeDone = 1'b1;
                end
            end
        end
    end

endmodule

/* src.f */
verilog/mmuPkg.sv
verilog/satpRegs.sv
verilog/tlbArray.sv
verilog/pageWalker.sv
verilog/translateFront.sv
verilog/mmuTop.sv
dv/mmuTbMem.sv
dv/mmuTb.sv

/* verilog/mmuPkg.sv */
package mmuPkg;

    localparam int vpnWidth = 20;

    // Bytes per Sv32 page-table entry
    localparam int pteBytes = 4;

    typedef struct packed {
        logic [9:0] vpn1;
        logic [9:0] vpn0;
    } vpnT;

    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0] ppn0;
    } ppnT;

    typedef logic [33:0] paddrT;

    // Sv32 PTE layout, valid in bit 0
    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0] ppn0;
        logic [1:0] rsw;
        logic dirty;
        logic accessed;
        logic global;
        logic user;
        logic execute;
        logic write;
        logic read;
        logic valid;
    } pageTableEntryT;

    typedef struct packed {
        logic dirty;
        logic user;
        logic execute;
        logic write;
        logic read;
    } tlbFlagsT;

    // Tag holds the full vpn, the TLB keeps only the bits above its index
    typedef struct packed {
        logic valid;
        logic fault;
        logic [vpnWidth-1:0] tag;
        ppnT pageNumber;
        tlbFlagsT flags;
    } tlbEntryT;

    typedef struct packed {
        logic mode;
        logic [8:0] asid;
        ppnT ppn;
    } satpT;

    typedef enum logic [1:0] {
        accessInstr,
        accessLoad,
        accessStore
    } accessTypeE;

    typedef enum logic [3:0] {
        idle,
        read1,
        decode1,
        write1,
        read0,
        decode0,
        write0,
        tlbWrite,
        tlbWriteFault
    } walkStateE;

    typedef struct packed {
        vpnT vpn;
        accessTypeE accessType;
    } xlateReqT;

    typedef struct packed {
        ppnT ppn;
        logic fault;
    } xlateRespT;

    typedef struct packed {
        satpT satp;
    } cfgWriteT;

endpackage

/* verilog/mmuTop.sv */
`timescale 1ns/10ps

module mmuTop #(
    parameter int lineWidth = 128,
    parameter int memAddrWidth = 30,
    parameter int tlbEntries = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic reqValid,
    output logic reqReady,
    input  mmuPkg::xlateReqT req,
    output logic respValid,
    input  logic respReady,
    output mmuPkg::xlateRespT resp,
    input  logic cfgValid,
    output logic cfgReady,
    input  mmuPkg::cfgWriteT cfg,
    output logic [memAddrWidth-1:0] memAddr,
    output logic memReadEnable,
    output logic memWriteEnable,
    output logic [lineWidth-1:0] memWriteValue,
    input  logic memReadDone,
    input  logic memWriteDone,
    input  logic [lineWidth-1:0] memReadValue
);
    import mmuPkg::*;

    satpT satp;
    logic flush;
    logic lookupValid;
    vpnT lookupVpn;
    logic hitValid;
    tlbEntryT hitEntry;
    logic walkEnable;
    logic walkDone;
    vpnT missPage;
    accessTypeE missAccessType;
    logic fillEnable;
    vpnT fillKey;
    tlbEntryT fillEntry;

    satpRegs satpRegs_inst (
        .clk(clk),
        .rst(rst),
        .cfgValid(cfgValid),
        .cfgReady(cfgReady),
        .cfg(cfg),
        .satp(satp),
        .flush(flush)
    );

    tlbArray #(
        .tlbEntries(tlbEntries)
    ) tlbArray_inst (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .lookupValid(lookupValid),
        .lookupVpn(lookupVpn),
        .hitValid(hitValid),
        .hitEntry(hitEntry),
        .fillEnable(fillEnable),
        .fillKey(fillKey),
        .fillEntry(fillEntry)
    );

    // Miss handling
    pageWalker #(
        .lineWidth(lineWidth),
        .memAddrWidth(memAddrWidth)
    ) pageWalker_inst (
        .clk(clk),
        .rst(rst),
        .enable(walkEnable),
        .done(walkDone),
        .missPage(missPage),
        .missAccessType(missAccessType),
        .satp(satp),
        .tlbWriteEnable(fillEnable),
        .tlbWriteKey(fillKey),
        .tlbWriteValue(fillEntry),
        .memAddr(memAddr),
        .memReadEnable(memReadEnable),
        .memWriteEnable(memWriteEnable),
        .memWriteValue(memWriteValue),
        .memReadDone(memReadDone),
        .memWriteDone(memWriteDone),
        .memReadValue(memReadValue)
    );

    translateFront translateFront_inst (
        .clk(clk),
        .rst(rst),
        .reqValid(reqValid),
        .reqReady(reqReady),
        .req(req),
        .respValid(respValid),
        .respReady(respReady),
        .resp(resp),
        .satp(satp),
        .lookupValid(lookupValid),
        .lookupVpn(lookupVpn),
        .hitValid(hitValid),
        .hitEntry(hitEntry),
        .walkEnable(walkEnable),
        .walkDone(walkDone),
        .missPage(missPage),
        .missAccessType(missAccessType)
    );

endmodule

/* verilog/pageWalker.sv */
`timescale 1ns/10ps

module pageWalker #(
    parameter int lineWidth = 128,
    parameter int memAddrWidth = 30
) (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    output logic done,
    input  mmuPkg::vpnT missPage,
    input  mmuPkg::accessTypeE missAccessType,
    input  mmuPkg::satpT satp,
    output logic tlbWriteEnable,
    output mmuPkg::vpnT tlbWriteKey,
    output mmuPkg::tlbEntryT tlbWriteValue,
    output logic [memAddrWidth-1:0] memAddr,
    output logic memReadEnable,
    output logic memWriteEnable,
    output logic [lineWidth-1:0] memWriteValue,
    input  logic memReadDone,
    input  logic memWriteDone,
    input  logic [lineWidth-1:0] memReadValue
);
    import mmuPkg::*;

    localparam int entriesPerLine = lineWidth / $bits(pageTableEntryT);
    localparam int slotWidth = $clog2(entriesPerLine);
    localparam int offsetWidth = $clog2(pteBytes);
    localparam int paddrWidth = $bits(paddrT);

    typedef logic [lineWidth-1:0] lineT;
    typedef logic [slotWidth-1:0] slotT;

    // ------------------------------
    // Entry helpers

    function automatic logic isLeaf(pageTableEntryT entry);
        return entry.read || entry.execute;
    endfunction

    // Invalid, or writable without read
    function automatic logic isBad(pageTableEntryT entry);
        return !entry.valid || (entry.write && !entry.read);
    endfunction

    function automatic slotT slotOf(paddrT addr);
        return addr[offsetWidth +: slotWidth];
    endfunction

    function automatic pageTableEntryT readSlot(lineT line, slotT slot);
        pageTableEntryT [entriesPerLine-1:0] entries;
        entries = line;
        return entries[slot];
    endfunction

    function automatic lineT mergeSlot(lineT line, pageTableEntryT entry, slotT slot);
        pageTableEntryT [entriesPerLine-1:0] entries;
        entries = line;
        entries[slot] = entry;
        return entries;
    endfunction

    function automatic pageTableEntryT markUsed(pageTableEntryT entry, accessTypeE access);
        pageTableEntryT ret;
        ret = entry;
        ret.accessed = 1'b1;
        if (access == accessStore) begin
            ret.dirty = 1'b1;
        end
        return ret;
    endfunction

    function automatic tlbFlagsT toFlags(pageTableEntryT entry);
        return '{dirty: entry.dirty, user: entry.user, execute: entry.execute,
                 write: entry.write, read: entry.read};
    endfunction

    walkStateE state;
    accessTypeE accessType;
    vpnT vpn;
    ppnT rootPpn;
    pageTableEntryT pte1;
    pageTableEntryT pte0;
    lineT line;
    ppnT fillPpn;
    tlbFlagsT fillFlags;

    paddrT addr1;
    paddrT addr0;
    pageTableEntryT used1;
    pageTableEntryT used0;

    always_comb begin
        addr1 = {rootPpn, vpn.vpn1, {offsetWidth{1'b0}}};
        addr0 = {pte1.ppn1, pte1.ppn0, vpn.vpn0, {offsetWidth{1'b0}}};
        used1 = markUsed(pte1, accessType);
        used0 = markUsed(pte0, accessType);
    end

    // ------------------------------
    // State sequence

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            unique case (state)
                idle: state <= enable ? read1 : idle;
                read1: state <= memReadDone ? decode1 : read1;
                decode1: begin
                    if (isBad(pte1)) begin
                        state <= tlbWriteFault;
                    end else begin
                        state <= isLeaf(pte1) ? write1 : read0;
                    end
                end
                write1: state <= memWriteDone ? tlbWrite : write1;
                read0: state <= memReadDone ? decode0 : read0;
                // No leaf after two levels is a fault as well
                decode0: state <= (isBad(pte0) || !isLeaf(pte0)) ? tlbWriteFault : write0;
                write0: state <= memWriteDone ? tlbWrite : write0;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && enable) begin
            vpn <= missPage;
            accessType <= missAccessType;
            rootPpn <= satp.ppn;
        end
        if (state == read1 && memReadDone) begin
            pte1 <= readSlot(memReadValue, slotOf(addr1));
            line <= memReadValue;
        end
        if (state == read0 && memReadDone) begin
            pte0 <= readSlot(memReadValue, slotOf(addr0));
            line <= memReadValue;
        end
        // Superpage takes its low ppn bits from the vpn
        if (state == decode1) begin
            fillPpn <= '{ppn1: used1.ppn1, ppn0: vpn.vpn0};
            fillFlags <= toFlags(used1);
        end
        if (state == decode0) begin
            fillPpn <= '{ppn1: used0.ppn1, ppn0: used0.ppn0};
            fillFlags <= toFlags(used0);
        end
    end

    // ------------------------------
    // Outputs

    always_comb begin
        done = (state == tlbWrite) || (state == tlbWriteFault);
        tlbWriteEnable = done;
        tlbWriteKey = vpn;
        tlbWriteValue.valid = 1'b1;
        tlbWriteValue.tag = vpn;
        if (state == tlbWriteFault) begin
            tlbWriteValue.fault = 1'b1;
            tlbWriteValue.pageNumber = '0;
            tlbWriteValue.flags = '0;
        end else begin
            tlbWriteValue.fault = 1'b0;
            tlbWriteValue.pageNumber = fillPpn;
            tlbWriteValue.flags = fillFlags;
        end

        if (state == read1 || state == decode1 || state == write1) begin
            memAddr = addr1[paddrWidth-1 -: memAddrWidth];
        end else begin
            memAddr = addr0[paddrWidth-1 -: memAddrWidth];
        end
        memReadEnable = (state == read1) || (state == read0);
        memWriteEnable = (state == write1) || (state == write0);

        unique case (state)
            write1: memWriteValue = mergeSlot(line, used1, slotOf(addr1));
            write0: memWriteValue = mergeSlot(line, used0, slotOf(addr0));
            default: memWriteValue = '0;
        endcase
    end

    assert property (@(posedge clk) disable iff (rst)
        !(memReadEnable && memWriteEnable));

    assert property (@(posedge clk) disable iff (rst)
        done |=> !done);

endmodule

/* verilog/satpRegs.sv */
`timescale 1ns/10ps

module satpRegs (
    input  logic clk,
    input  logic rst,
    input  logic cfgValid,
    output logic cfgReady,
    input  mmuPkg::cfgWriteT cfg,
    output mmuPkg::satpT satp,
    output logic flush
);

    logic accepted;

    // Writes are never stalled
    assign cfgReady = 1'b1;
    assign accepted = cfgValid && cfgReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            satp <= '0;
            flush <= 1'b0;
        end else begin
            // Any rewrite of satp drops all cached translations
            flush <= accepted;
            if (accepted) begin
                satp <= cfg.satp;
            end
        end
    end

    // ------------------------------
    // Checks

    assert property (@(posedge clk) disable iff (rst)
        flush |-> $past(accepted));

endmodule

/* verilog/tlbArray.sv */
`timescale 1ns/10ps

module tlbArray #(
    parameter int tlbEntries = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic lookupValid,
    input  mmuPkg::vpnT lookupVpn,
    output logic hitValid,
    output mmuPkg::tlbEntryT hitEntry,
    input  logic fillEnable,
    input  mmuPkg::vpnT fillKey,
    input  mmuPkg::tlbEntryT fillEntry
);
    import mmuPkg::*;

    localparam int indexWidth = $clog2(tlbEntries);
    localparam int tagWidth = vpnWidth - indexWidth;

    typedef logic [indexWidth-1:0] indexT;
    typedef logic [tagWidth-1:0] tagT;

    // Entry contents other than valid and tag
    typedef struct packed {
        logic fault;
        ppnT pageNumber;
        tlbFlagsT flags;
    } slotT;

    logic [tlbEntries-1:0] validBits;
    tagT tagMem [tlbEntries];
    slotT slotMem [tlbEntries];

    indexT lookupIndex;
    tagT lookupTag;
    indexT fillIndex;
    tagT fillTag;
    slotT fillSlot;
    logic readValid;
    tagT readTag;
    slotT readSlot;

    always_comb begin
        lookupIndex = lookupVpn[indexWidth-1:0];
        lookupTag = lookupVpn[vpnWidth-1:indexWidth];
        fillIndex = fillKey[indexWidth-1:0];
        fillTag = fillEntry.tag[vpnWidth-1:indexWidth];
        fillSlot = '{fault: fillEntry.fault, pageNumber: fillEntry.pageNumber,
                     flags: fillEntry.flags};

        readValid = validBits[lookupIndex] && !flush;
        readTag = tagMem[lookupIndex];
        readSlot = slotMem[lookupIndex];
        // A fill on the same edge wins, so the retry after a walk hits
        if (fillEnable && (fillIndex == lookupIndex)) begin
            readValid = fillEntry.valid;
            readTag = fillTag;
            readSlot = fillSlot;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
            hitValid <= 1'b0;
        end else begin
            if (flush) begin
                validBits <= '0;
            end
            if (fillEnable) begin
                validBits[fillIndex] <= fillEntry.valid;
            end
            hitValid <= lookupValid && readValid && (readTag == lookupTag);
        end
    end

    always_ff @(posedge clk) begin
        if (fillEnable) begin
            tagMem[fillIndex] <= fillTag;
            slotMem[fillIndex] <= fillSlot;
        end
        if (lookupValid) begin
            hitEntry.valid <= readValid;
            hitEntry.fault <= readSlot.fault;
            hitEntry.tag <= {readTag, lookupIndex};
            hitEntry.pageNumber <= readSlot.pageNumber;
            hitEntry.flags <= readSlot.flags;
        end
    end

endmodule

/* verilog/translateFront.sv */
`timescale 1ns/10ps

module translateFront (
    input  logic clk,
    input  logic rst,
    input  logic reqValid,
    output logic reqReady,
    input  mmuPkg::xlateReqT req,
    output logic respValid,
    input  logic respReady,
    output mmuPkg::xlateRespT resp,
    input  mmuPkg::satpT satp,
    output logic lookupValid,
    output mmuPkg::vpnT lookupVpn,
    input  logic hitValid,
    input  mmuPkg::tlbEntryT hitEntry,
    output logic walkEnable,
    input  logic walkDone,
    output mmuPkg::vpnT missPage,
    output mmuPkg::accessTypeE missAccessType
);
    import mmuPkg::*;

    typedef enum logic [2:0] {
        frontIdle,
        frontLookup,
        frontWalk,
        frontRetry,
        frontRespond
    } frontStateE;

    frontStateE state;
    xlateReqT pending;
    logic accept;
    logic bareMode;

    // Cached fault or missing permission for the access
    function automatic xlateRespT checkEntry(tlbEntryT entry, accessTypeE access);
        xlateRespT ret;
        logic denied;
        case (access)
            accessInstr: denied = !entry.flags.execute;
            accessLoad: denied = !entry.flags.read;
            default: denied = !entry.flags.write;
        endcase
        ret.ppn = entry.pageNumber;
        ret.fault = entry.fault || denied;
        return ret;
    endfunction

    function automatic xlateRespT bareResp(vpnT vpn);
        xlateRespT ret;
        ret.ppn = {2'b00, vpn};
        ret.fault = 1'b0;
        return ret;
    endfunction

    always_comb begin
        reqReady = (state == frontIdle);
        respValid = (state == frontRespond);
        accept = reqValid && reqReady;
        bareMode = (satp.mode == 1'b0);
        // Retry lookup goes out with walkDone, the TLB forwards the fill
        lookupValid = (accept && !bareMode) || (state == frontWalk && walkDone);
        lookupVpn = (state == frontIdle) ? req.vpn : pending.vpn;
        walkEnable = (state == frontWalk);
        missPage = pending.vpn;
        missAccessType = pending.accessType;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= frontIdle;
        end else begin
            unique case (state)
                frontIdle: begin
                    if (accept) begin
                        state <= bareMode ? frontRespond : frontLookup;
                    end
                end
                frontLookup, frontRetry: state <= hitValid ? frontRespond : frontWalk;
                frontWalk: state <= walkDone ? frontRetry : frontWalk;
                default: state <= respReady ? frontIdle : frontRespond;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pending <= req;
            if (bareMode) begin
                resp <= bareResp(req.vpn);
            end
        end
        if ((state == frontLookup || state == frontRetry) && hitValid) begin
            resp <= checkEntry(hitEntry, pending.accessType);
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        respValid && !respReady |=> respValid && $stable(resp));

endmodule
